// ==== gb_cart_pkg.sv ====
package gb_cart_pkg;

	// ------------------------------
	// cartridge header in the download stream
	// ------------------------------

	// byte addresses of the two 16-bit header words we care about
	localparam logic [24:0] HDR_TYPE_OFS = 25'h146; // sgb flag + cart type
	localparam logic [24:0] HDR_SIZE_OFS = 25'h148; // rom size + ram size

	// ------------------------------
	// widths
	// ------------------------------

	localparam int ROM_BANK_W  = 9;  // mbc5 goes up to 512 banks
	localparam int RAM_BANK_W  = 4;  // 16 banks of 8k max
	localparam int CRAM_ADDR_W = 17; // 128k byte address into cart ram
	localparam int ROM_WADDR_W = 24; // word address into external rom memory
	localparam int LBA_W       = 8;  // sector counter bits that matter

	// writing this to 0000-1fff turns cart ram on
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

	// ------------------------------
	// types
	// ------------------------------

	// memory bank controller families handled here
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0, // plain 32k rom
		MBC_1    = 3'd1,
		MBC_2    = 3'd2, // 512x4 bit ram on chip
		MBC_3    = 3'd3, // rtc not modelled
		MBC_5    = 3'd4
	} mbc_kind_t;

	// download word is little endian, so the odd byte sits on top
	// 0x146: {type @0x147, sgb flag @0x146}
	// 0x148: {ram size @0x149, rom size @0x148}
	typedef union packed {
		struct packed {
			logic [7:0] mbc_type;
			logic [7:0] sgb_flag;
		} type_w;
		struct packed {
			logic [7:0] ram_size;
			logic [7:0] rom_size;
		} size_w;
	} hdr_word_u;

endpackage

// ==== cart_header.sv ====
`timescale 1ns/1ps

module cart_header (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                cart_download,
	input  logic                                ioctl_wr,
	input  logic [24:0]                         ioctl_addr,
	input  logic [15:0]                         ioctl_dout,
	output gb_cart_pkg::mbc_kind_t              mbc_kind,
	output logic [gb_cart_pkg::ROM_BANK_W-1:0] rom_mask,
	output logic [gb_cart_pkg::RAM_BANK_W-1:0] ram_mask,
	output logic [7:0]                          ram_size_code,
	output logic                                has_battery
);
	import gb_cart_pkg::*;

	hdr_word_u  dl_word;  // current download word, two views
	logic [7:0] mbc_type; // raw cart type byte
	logic [7:0] rom_size; // raw rom size code

	assign dl_word = ioctl_dout;

	// grab the header bytes as they fly past
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mbc_type      <= 8'h00;
			rom_size      <= 8'h00;
			ram_size_code <= 8'h00;
		end else if (cart_download && ioctl_wr) begin
			if (ioctl_addr == HDR_TYPE_OFS)
				mbc_type <= dl_word.type_w.mbc_type;
			if (ioctl_addr == HDR_SIZE_OFS) begin
				ram_size_code <= dl_word.size_w.ram_size;
				rom_size      <= dl_word.size_w.rom_size;
			end
		end
	end

	// ------------------------------
	// decode
	// ------------------------------
	always_comb begin
		case (mbc_type)
			8'h01, 8'h02, 8'h03:                      mbc_kind = MBC_1;
			8'h05, 8'h06:                             mbc_kind = MBC_2;
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:        mbc_kind = MBC_3;
			8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: mbc_kind = MBC_5;
			default:                                  mbc_kind = MBC_NONE; // incl. unsupported mappers
		endcase

		// code n means 2<<n banks; the odd 0x52-0x54 sizes fall back to 128 banks
		if (rom_size <= 8'd8)
			rom_mask = 9'h1FF >> (4'd8 - rom_size[3:0]);
		else
			rom_mask = 9'h07F;

		if (ram_size_code <= 8'd2)
			ram_mask = 4'h0; // 2k or 8k, single bank
		else if (ram_size_code == 8'd3)
			ram_mask = 4'h3; // 32k
		else
			ram_mask = 4'hF; // 128k

		case (mbc_type)
			8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
			8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF: has_battery = 1'b1;
			default:                           has_battery = 1'b0;
		endcase
	end

endmodule

// ==== mbc_regs.sv ====
`timescale 1ns/1ps

module mbc_regs (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                cpu_ce,
	input  logic                                cart_wr,
	input  logic [15:0]                         cart_addr,
	input  logic [7:0]                          cart_di,
	input  gb_cart_pkg::mbc_kind_t              mbc_kind,
	output logic [gb_cart_pkg::ROM_BANK_W-1:0] rom_bank,
	output logic [gb_cart_pkg::RAM_BANK_W-1:0] ram_bank,
	output logic                                mbc1_mode,
	output logic                                rtc_mode,
	output logic                                ram_enable
);
	import gb_cart_pkg::*;

	logic reg_wr; // qualified cpu write into the rom area

	assign reg_wr = cpu_ce && cart_wr && !cart_addr[15];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= 9'd1; // bank 0 is never mapped high
			ram_bank   <= 4'd0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (cart_addr[14:13])
				// ------------------------------
				// 0000-1fff ram enable
				2'b00: ram_enable <= (cart_di[3:0] == RAM_ENABLE_KEY);

				// ------------------------------
				// 2000-3fff rom bank
				2'b01: begin
					if (mbc_kind == MBC_5) begin
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];   // 3000-3fff high bit
						else
							rom_bank[7:0] <= cart_di;    // 2000-2fff low byte
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank <= 9'd1;                // 0 reads as 1 on older mappers
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end

				// ------------------------------
				// 4000-5fff ram bank or rtc select
				2'b10: begin
					if (mbc_kind == MBC_3) begin
						rtc_mode <= cart_di[3];          // 08-0c pick a clock register
						if (!cart_di[3])
							ram_bank <= {2'b00, cart_di[1:0]};
					end else if (mbc_kind == MBC_5) begin
						ram_bank <= cart_di[3:0];
					end else begin
						ram_bank <= {2'b00, cart_di[1:0]}; // mbc1 upper bits
					end
				end

				// ------------------------------
				// 6000-7fff banking mode, mbc1 only
				default: begin
					if (mbc_kind == MBC_1)
						mbc1_mode <= cart_di[0];
				end
			endcase
		end
	end

endmodule

// ==== cart_addr_map.sv ====
`timescale 1ns/1ps

module cart_addr_map (
	input  logic                                 cart_download,
	input  logic [24:0]                          ioctl_addr,
	input  logic [15:0]                          cart_addr,
	input  gb_cart_pkg::mbc_kind_t               mbc_kind,
	input  logic [gb_cart_pkg::ROM_BANK_W-1:0]  rom_bank,
	input  logic [gb_cart_pkg::RAM_BANK_W-1:0]  ram_bank,
	input  logic                                 mbc1_mode,
	input  logic [gb_cart_pkg::ROM_BANK_W-1:0]  rom_mask,
	input  logic [gb_cart_pkg::RAM_BANK_W-1:0]  ram_mask,
	output logic [gb_cart_pkg::ROM_WADDR_W-1:0] rom_addr,
	output logic [gb_cart_pkg::CRAM_ADDR_W-1:0] cram_addr
);
	import gb_cart_pkg::*;

	logic                  hi_window; // 4000-7fff switchable area
	logic [ROM_BANK_W-1:0] bank_raw;  // bank before mirroring
	logic [ROM_BANK_W-1:0] rom_sel;   // bank actually driven out
	logic [RAM_BANK_W-1:0] ram_sel;

	assign hi_window = (cart_addr[15:14] == 2'b01);

	always_comb begin
		// per mapper view of the bank register
		case (mbc_kind)
			MBC_1:   bank_raw = {2'b00, mbc1_mode ? 2'b00 : ram_bank[1:0], rom_bank[4:0]};
			MBC_2:   bank_raw = {5'd0, rom_bank[3:0]};
			MBC_3:   bank_raw = {2'b00, rom_bank[6:0]};
			default: bank_raw = rom_bank; // mbc5 full 9 bits
		endcase

		if (mbc_kind == MBC_NONE)
			rom_sel = {8'd0, hi_window}; // flat 32k
		else if (hi_window)
			rom_sel = bank_raw & rom_mask; // mirror on small roms
		else
			rom_sel = '0; // 0000-3fff is fixed bank 0

		// mbc1 only banks ram in mode 1
		case (mbc_kind)
			MBC_1:        ram_sel = (mbc1_mode ? {2'b00, ram_bank[1:0]} : 4'd0) & ram_mask;
			MBC_3, MBC_5: ram_sel = ram_bank & ram_mask;
			default:      ram_sel = 4'd0;
		endcase
	end

	// 16-bit wide rom, so the byte address drops bit 0
	assign rom_addr  = cart_download ? ioctl_addr[24:1] : {2'b00, rom_sel, cart_addr[13:1]};
	assign cram_addr = {ram_sel, cart_addr[12:0]};

endmodule

// ==== cart_ram.sv ====
`timescale 1ns/1ps

module cart_ram (
	input  logic                                 clk_sys,
	input  logic [15:0]                          cart_addr,
	input  logic                                 cart_rd,
	input  logic                                 cart_wr,
	input  logic [7:0]                           cart_di,
	input  logic [gb_cart_pkg::CRAM_ADDR_W-1:0] cram_addr,
	input  gb_cart_pkg::mbc_kind_t               mbc_kind,
	input  logic                                 ram_enable,
	input  logic                                 rtc_mode,
	input  logic [15:0]                          rom_dout,
	input  logic [7:0]                           sd_buff_addr,
	input  logic                                 sd_buff_wr,
	input  logic                                 sd_ack,
	input  logic [15:0]                          sd_buff_dout,
	input  logic [gb_cart_pkg::LBA_W-1:0]       sd_lba,
	output logic [7:0]                           cart_do,
	output logic [15:0]                          sd_buff_din,
	output logic                                 cram_wr
);
	import gb_cart_pkg::*;

	localparam int HALF_AW = CRAM_ADDR_W - 1; // 64k per byte lane

	logic               is_cram;   // cpu in a000-bfff
	logic               bk_wr;     // backup buffer write
	logic [HALF_AW-1:0] bk_addr;   // word address from the image side
	logic [7:0]         q_a [2];   // cpu port read data per half
	logic [7:0]         q_b [2];   // backup port read data per half
	logic               lane_q;    // which half the last cpu read hit
	logic [7:0]         cram_q;
	logic [7:0]         cram_do;

	assign is_cram = (cart_addr[15:13] == 3'b101);
	assign cram_wr = cart_wr && is_cram;
	assign bk_wr   = sd_buff_wr && sd_ack;
	assign bk_addr = {sd_lba, sd_buff_addr};

	// ------------------------------
	// even / odd byte halves
	// ------------------------------
	for (genvar h = 0; h < 2; h++) begin : g_half
		logic [7:0] mem [0:(1<<HALF_AW)-1];

		always_ff @(posedge clk_sys) begin
			if (cram_wr && cram_addr[0] == 1'(h))
				mem[cram_addr[CRAM_ADDR_W-1:1]] <= cart_di;
			q_a[h] <= mem[cram_addr[CRAM_ADDR_W-1:1]];
			if (bk_wr)
				mem[bk_addr] <= sd_buff_dout[8*h +: 8]; // image word, low byte even
			q_b[h] <= mem[bk_addr];
		end
	end

	always_ff @(posedge clk_sys)
		lane_q <= cram_addr[0]; // follows the registered read

	assign cram_q      = lane_q ? q_a[1] : q_a[0];
	assign sd_buff_din = {q_b[1], q_b[0]};

	// mbc2 ram is 4 bits wide, top nibble floats high
	always_comb begin
		if (!ram_enable)
			cram_do = 8'hFF;
		else if (rtc_mode)
			cram_do = 8'h00; // no clock behind it
		else if (mbc_kind == MBC_2 && cart_addr[15:9] == 7'b1010000)
			cram_do = {4'hF, cram_q[3:0]};
		else
			cram_do = cram_q;
	end

	// rom bytes come straight from the external word
	assign cart_do = (cart_rd && is_cram) ? cram_do :
		cart_addr[0] ? rom_dout[15:8] : rom_dout[7:0];

endmodule

// ==== backup_seq.sv ====
`timescale 1ns/1ps

module backup_seq (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_download,
	input  logic                   cram_wr,
	input  gb_cart_pkg::mbc_kind_t mbc_kind,
	input  logic [7:0]             ram_size_code,
	input  logic                   has_battery,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic [63:0]            img_size,
	input  logic                   osd_status,
	input  logic                   bk_load_req,
	input  logic                   bk_save_req,
	input  logic                   autosave_en,
	input  logic                   sd_ack,
	output logic [31:0]            sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   sav_pending
);
	import gb_cart_pkg::*;

	logic             dl_q, load_q, save_q, ack_q; // previous cycle copies for edges
	logic             bk_ena;     // writable image seen during download
	logic             bk_busy;    // transfer in progress
	logic             bk_loading; // direction of the running transfer
	logic             sav_supported;
	logic             bk_save;    // manual or automatic save request
	logic             load_edge, save_edge, dl_load;
	logic             start, start_load;
	logic [LBA_W-1:0] last_sector;

	assign sav_supported = has_battery && (ram_size_code != 8'd0 || mbc_kind == MBC_2) && bk_ena;
	assign bk_save       = bk_save_req || (sav_pending && osd_status && autosave_en);

	assign load_edge  = bk_ena && bk_load_req && !load_q;
	assign save_edge  = bk_ena && bk_save && !save_q;
	assign dl_load    = bk_ena && dl_q && !cart_download && (img_size != 64'd0); // fresh cart
	assign start      = !bk_busy && (load_edge || save_edge || dl_load);
	assign start_load = load_edge || dl_load; // load wins over a save edge

	// image sectors are 512 bytes
	always_comb begin
		if (mbc_kind == MBC_2)
			last_sector = 8'h01;
		else
			case (ram_size_code)
				8'd1:    last_sector = 8'h03;
				8'd2:    last_sector = 8'h0F;
				8'd3:    last_sector = 8'h3F;
				default: last_sector = 8'hFF;
			endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{dl_q, load_q, save_q, ack_q} <= 4'b0000;
			bk_ena      <= 1'b0;
			bk_busy     <= 1'b0;
			bk_loading  <= 1'b0;
			sav_pending <= 1'b0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			sd_lba      <= 32'd0;
		end else begin
			dl_q   <= cart_download;
			load_q <= bk_load_req;
			save_q <= bk_save;
			ack_q  <= sd_ack;

			// new cart forgets the old image unless one mounts again
			if (cart_download && !dl_q)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (start)
				sav_pending <= 1'b0;

			if (sd_ack && !ack_q)
				{sd_rd, sd_wr} <= 2'b00; // host took the request

			// ------------------------------
			// sector stepping
			if (start) begin
				bk_busy    <= 1'b1;
				bk_loading <= start_load;
				sd_lba     <= 32'd0;
				sd_rd      <= start_load;
				sd_wr      <= !start_load;
			end else if (bk_busy && ack_q && !sd_ack) begin
				if (sd_lba[LBA_W-1:0] >= last_sector) begin
					bk_busy    <= 1'b0; // done
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

// ==== gb_cart_top.sv ====
`timescale 1ns/1ps

module gb_cart_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	// rom image download
	input  logic                                 cart_download,
	input  logic                                 ioctl_wr,
	input  logic [24:0]                          ioctl_addr,
	input  logic [15:0]                          ioctl_dout,
	// cpu cartridge bus
	input  logic                                 cpu_ce,
	input  logic [15:0]                          cart_addr,
	input  logic                                 cart_rd,
	input  logic                                 cart_wr,
	input  logic [7:0]                           cart_di,
	output logic [7:0]                           cart_do,
	// external rom memory
	output logic [gb_cart_pkg::ROM_WADDR_W-1:0] rom_addr,
	output logic                                 rom_we,
	output logic [15:0]                          rom_din,
	input  logic [15:0]                          rom_dout,
	// save image
	output logic [31:0]                          sd_lba,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	input  logic                                 sd_ack,
	input  logic [7:0]                           sd_buff_addr,
	input  logic                                 sd_buff_wr,
	input  logic [15:0]                          sd_buff_dout,
	output logic [15:0]                          sd_buff_din,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic [63:0]                          img_size,
	// user side
	input  logic                                 osd_status,
	input  logic                                 bk_load_req,
	input  logic                                 bk_save_req,
	input  logic                                 autosave_en,
	output logic                                 sav_pending
);
	import gb_cart_pkg::*;

	mbc_kind_t              mbc_kind;
	logic [ROM_BANK_W-1:0]  rom_mask, rom_bank;
	logic [RAM_BANK_W-1:0]  ram_mask, ram_bank;
	logic [7:0]             ram_size_code;
	logic                   has_battery, mbc1_mode, rtc_mode, ram_enable;
	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic                   cram_wr; // cpu write into cart ram

	// download words go straight into rom memory
	assign rom_we  = cart_download && ioctl_wr;
	assign rom_din = ioctl_dout;

	cart_header   u_header (.*);
	mbc_regs      u_regs   (.*);
	cart_addr_map u_map    (.*);
	cart_ram      u_ram    (.sd_lba(sd_lba[LBA_W-1:0]), .*); // low lba bits index the buffer
	backup_seq    u_backup (.*);

endmodule

// ==== gb_cart_assertions.sv ====
`timescale 1ns/1ps

module gb_cart_assertions (
	input logic                   clk_sys,
	input logic                   reset,
	input logic [31:0]            sd_lba,
	input logic                   sd_rd,
	input logic                   sd_wr,
	input logic                   sd_ack,
	input logic                   sav_pending,
	input gb_cart_pkg::mbc_kind_t mbc_kind,
	input logic [7:0]             ram_size_code
);
	import gb_cart_pkg::*;

	int         fail_count = 0; // failed assertions, read by the testbench
	logic [7:0] last_sec;       // highest 512 byte sector of the save

	always_comb begin
		case (ram_size_code)
			8'd1:    last_sec = 8'h03; // 2k
			8'd2:    last_sec = 8'h0F; // 8k
			8'd3:    last_sec = 8'h3F; // 32k
			default: last_sec = 8'hFF; // 128k
		endcase
		if (mbc_kind == MBC_2)
			last_sec = 8'h01; // 512 nibbles padded to bytes
	end

	// ------------------------------
	// image request handshake
	// ------------------------------
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else begin
			fail_count++;
			$error("sd_rd and sd_wr asserted together");
		end

	a_lba_range: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> (sd_lba <= {24'd0, last_sec}))
		else begin
			fail_count++;
			$error("sector request beyond the last save sector");
		end

	a_req_drop: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_ack) |=> !(sd_rd || sd_wr))
		else begin
			fail_count++;
			$error("request still high after the ack edge");
		end

	a_reset_idle: assert property (@(posedge clk_sys) reset |=> !(sd_rd || sd_wr || sav_pending))
		else begin
			fail_count++;
			$error("backup outputs not idle after reset");
		end

endmodule

bind gb_cart_top gb_cart_assertions chk (.*);

// ==== tb_gb_cart.sv ====
`timescale 1ns/1ps

module tb_gb_cart;

	localparam int CLK_PERIOD  = 40;
	localparam int SECTORS     = 64;  // 32k save for ram code 3
	localparam int WORDS       = 256; // words per sector
	localparam int WATCHDOG_NS = (2 * SECTORS * (WORDS + 16) + 4000) * CLK_PERIOD;

	logic        clk_sys, reset;
	logic        cart_download, ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        cpu_ce, cart_rd, cart_wr;
	logic [15:0] cart_addr;
	logic [7:0]  cart_di, cart_do;
	logic [23:0] rom_addr;
	logic        rom_we;
	logic [15:0] rom_din, rom_dout;
	logic [31:0] sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [7:0]  sd_buff_addr;
	logic [15:0] sd_buff_dout, sd_buff_din;
	logic        img_mounted, img_readonly;
	logic [63:0] img_size;
	logic        osd_status, bk_load_req, bk_save_req, autosave_en, sav_pending;

	logic [15:0] rom_mem [0:65535]; // word i holds i
	logic [15:0] img_mem [0:65535]; // 256 sectors x 256 words
	logic [31:0] rng;
	logic [14:0] save_addr [8];     // cart ram byte addresses
	logic [7:0]  save_data [8];
	logic [14:0] b;
	int          errors, rd_sectors, wr_sectors;

	gb_cart_top dut (.*);

	assign rom_dout = rom_mem[rom_addr[15:0]];

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// word address of a cpu rom access: 16k byte banks, 16-bit words
	function automatic logic [23:0] rom_word(input logic [8:0] bank, input logic [15:0] a);
		return 24'(bank) * 24'h2000 + 24'(a[13:1]);
	endfunction

	function automatic logic [7:0] image_byte(input logic [14:0] ba);
		logic [15:0] w;
		w = img_mem[{2'b00, ba[14:1]}];
		return ba[0] ? w[15:8] : w[7:0]; // odd byte in the high half
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic load_cart(input logic [7:0] cart_type, input logic [7:0] rom_code,
			input logic [7:0] ram_code, input logic mount, input logic [63:0] size);
		img_mounted   = mount;
		img_size      = size;
		cart_download = 1'b1;
		ioctl_wr      = 1'b1;
		ioctl_addr    = 25'h146;
		ioctl_dout    = {cart_type, 8'h00};
		next_cycle();
		ioctl_addr = 25'h148;
		ioctl_dout = {ram_code, rom_code};
		@(negedge clk_sys);
		check_val("dl_rom_addr", 32'h0000A4, 32'(rom_addr)); // byte 0x148 is word 0xa4
		check_val("dl_rom_we", 32'd1, 32'(rom_we));
		check_val("dl_rom_din", 32'({ram_code, rom_code}), 32'(rom_din));
		next_cycle();
		cart_download = 1'b0;
		img_mounted   = 1'b0;
		@(negedge clk_sys);
		check_val("rom_we_idle", 32'd0, 32'(rom_we)); // strobe left high, no download
		next_cycle();
		ioctl_wr = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cart_addr = a;
		cart_di   = d;
		cart_wr   = 1'b1;
		cpu_ce    = 1'b1;
		next_cycle();
		cart_wr = 1'b0;
		cpu_ce  = 1'b0;
	endtask

	task automatic check_rom(input string name, input logic [15:0] a, input logic [8:0] bank);
		cart_addr = a;
		@(negedge clk_sys);
		check_val(name, 32'(rom_word(bank, a)), 32'(rom_addr));
		next_cycle();
	endtask

	task automatic check_read(input string name, input logic [15:0] a, input logic [7:0] exp);
		cart_addr = a;
		cart_rd   = 1'b1;
		next_cycle(); // ram data registered here
		@(negedge clk_sys);
		check_val(name, 32'(exp), 32'(cart_do));
		next_cycle();
		cart_rd = 1'b0;
	endtask

	task automatic wait_transfer();
		while (!dut.u_backup.bk_busy)
			next_cycle();
		while (dut.u_backup.bk_busy || sd_rd || sd_wr)
			next_cycle();
	endtask

	// ------------------------------
	// image side, acks each request a few cycles late
	// ------------------------------
	initial begin : image_model
		logic [7:0] lba;
		logic       loading;
		sd_ack       = 1'b0;
		sd_buff_wr   = 1'b0;
		sd_buff_addr = 8'h00;
		sd_buff_dout = 16'h0000;
		rd_sectors   = 0;
		wr_sectors   = 0;
		forever begin
			next_cycle();
			if (sd_rd || sd_wr) begin
				lba     = sd_lba[7:0];
				loading = sd_rd;
				if (loading)
					rd_sectors++;
				else
					wr_sectors++;
				repeat (3)
					next_cycle();
				sd_ack = 1'b1;
				for (int i = 0; i <= WORDS; i++) begin
					if (i > 0 && !loading)
						img_mem[{lba, 8'(i - 1)}] = sd_buff_din; // read data lags a cycle
					if (i < WORDS) begin
						sd_buff_addr = 8'(i);
						sd_buff_dout = img_mem[{lba, 8'(i)}];
						sd_buff_wr   = loading;
						next_cycle();
					end
				end
				sd_ack     = 1'b0;
				sd_buff_wr = 1'b0;
			end
		end
	end

	initial begin
		rng    = 32'hd96c8fc2;
		errors = 0;
		reset  = 1'b1;
		{cart_download, ioctl_wr, cpu_ce, cart_rd, cart_wr} = 5'b00000;
		ioctl_addr = 25'd0;
		ioctl_dout = 16'h0000;
		cart_addr  = 16'h0000;
		cart_di    = 8'h00;
		{img_mounted, img_readonly, osd_status} = 3'b000;
		{bk_load_req, bk_save_req, autosave_en} = 3'b000;
		img_size = 64'd0;
		for (int i = 0; i < 65536; i++)
			rom_mem[16'(i)] = 16'(i);
		repeat (4)
			@(posedge clk_sys);
		#2;
		reset = 1'b0;

		// mbc1 with 64 banks
		load_cart(8'h01, 8'h05, 8'h00, 1'b0, 64'd0);
		cpu_write(16'h2000, 8'h13);
		check_rom("mbc1_bank", 16'h4000, 9'h013);
		cpu_write(16'h4000, 8'h03); // bank 0x73, top bit outside the 6 bit mask
		check_rom("mbc1_mask", 16'h4000, 9'h033);
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'h2000, 8'h00);
		check_rom("mbc1_zero", 16'h5FFE, 9'h001);
		check_rom("mbc1_fixed", 16'h1234, 9'h000);
		check_read("mbc1_rom_byte", 16'h4001, 8'h20);

		// mbc5 ninth bank bit
		load_cart(8'h19, 8'h08, 8'h00, 1'b0, 64'd0);
		cpu_write(16'h3000, 8'h01);
		cpu_write(16'h2000, 8'h5A);
		check_rom("mbc5_bank9", 16'h7FFE, 9'h15A);

		// ram enable, then mbc2 nibble ram
		load_cart(8'h02, 8'h01, 8'h02, 1'b0, 64'd0);
		cpu_write(16'hA123, 8'h3C);
		check_read("ram_disabled", 16'hA123, 8'hFF);
		cpu_write(16'h0000, 8'h0A);
		rng = lcg(rng);
		cpu_write(16'hA123, rng[15:8]);
		check_read("ram_readback", 16'hA123, rng[15:8]);
		load_cart(8'h06, 8'h01, 8'h00, 1'b0, 64'd0);
		cpu_write(16'hA010, 8'h5C);
		check_read("mbc2_nibble", 16'hA010, 8'hFC);

		// mbc3 ram banks and clock select
		load_cart(8'h13, 8'h02, 8'h03, 1'b0, 64'd0);
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA555, 8'h11);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hA555, 8'h22);
		check_read("mbc3_bank2", 16'hA555, 8'h22);
		cpu_write(16'h4000, 8'h00);
		check_read("mbc3_bank0", 16'hA555, 8'h11);
		cpu_write(16'h4000, 8'h08);
		check_read("mbc3_rtc", 16'hA555, 8'h00);
		cpu_write(16'h4000, 8'h00);

		// ------------------------------
		// save to a writable image
		// ------------------------------
		load_cart(8'h1B, 8'h05, 8'h03, 1'b1, 64'd0);
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 8; i++) begin
			rng = lcg(rng);
			save_addr[3'(i)] = {3'(i), rng[11:0]}; // one address per 4k
			save_data[3'(i)] = rng[23:16];
			b = save_addr[3'(i)];
			cpu_write(16'h4000, {6'd0, b[14:13]});
			cpu_write({3'b101, b[12:0]}, save_data[3'(i)]);
			if (i == 0)
				check_val("save_pending_set", 32'd1, 32'(sav_pending));
		end
		bk_save_req = 1'b1;
		next_cycle();
		bk_save_req = 1'b0;
		wait_transfer();
		check_val("save_sectors", 32'(SECTORS), 32'(wr_sectors));
		check_val("save_pending_clear", 32'd0, 32'(sav_pending));
		for (int i = 0; i < 8; i++)
			check_val("save_image", 32'(save_data[3'(i)]), 32'(image_byte(save_addr[3'(i)])));

		// ------------------------------
		// load after download
		// ------------------------------
		for (int w = 0; w < 65536; w++) begin
			rng = lcg(rng);
			img_mem[16'(w)] = rng[31:16];
		end
		load_cart(8'h1B, 8'h05, 8'h03, 1'b1, 64'd32768);
		wait_transfer();
		check_val("load_sectors", 32'(SECTORS), 32'(rd_sectors));
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 8; i++) begin
			rng = lcg(rng);
			b   = {3'(i), rng[11:0]};
			cpu_write(16'h4000, {6'd0, b[14:13]});
			check_read("load_ram", {3'b101, b[12:0]}, image_byte(b));
		end

		$display("errors: %0d value, %0d assertion", errors, dut.chk.fail_count);
		if (errors == 0 && dut.chk.fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== gb_cart.f ====
gb_cart_pkg.sv
cart_header.sv
mbc_regs.sv
cart_addr_map.sv
cart_ram.sv
backup_seq.sv
gb_cart_top.sv
gb_cart_assertions.sv
tb_gb_cart.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f gb_cart.f --top-module tb_gb_cart -o sim_gb_cart
	./obj_dir/sim_gb_cart +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
